/* noc_cfg.svh */
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// mesh coordinate and flit data widths
`define NOC_COORD_W 3
`define NOC_PAYLOAD_W 16

// input buffer depth, also the credits each upstream sender starts with
`define NOC_FIFO_DEPTH 4

// buffer depth of the west neighbour
`define NOC_W_CREDITS 3

// position of this router in the mesh
`define NOC_MY_X 3
`define NOC_MY_Y 3

`endif

/* noc_pkg.sv */
`include "noc_cfg.svh"

package noc_pkg;

  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // five-way port code, same order as the crossbar select
  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_S = 3'd1,
    PORT_W = 3'd2,
    PORT_E = 3'd3,
    PORT_L = 3'd4
  } port_e;

  // bit position of each arbitrated input
  typedef enum logic [1:0] {
    IDX_L = 2'd0,
    IDX_E = 2'd1,
    IDX_S = 2'd2,
    IDX_N = 2'd3
  } in_idx_e;

  typedef struct packed {
    coord_t                    dest_x;
    coord_t                    dest_y;
    port_e                     src;
    logic [`NOC_PAYLOAD_W-1:0] payload;
  } flit_t;

  typedef struct packed {
    logic  valid;
    flit_t flit;
  } flit_link_t;

  // buffer occupancy and credit counts
  typedef logic [$clog2(`NOC_FIFO_DEPTH)-1:0]   fifo_ptr_t;
  typedef logic [$clog2(`NOC_FIFO_DEPTH+1)-1:0] fifo_cnt_t;
  typedef logic [$clog2(`NOC_W_CREDITS+1)-1:0]  w_credit_cnt_t;

endpackage

/* credit_fifo.sv */
`timescale 1ns/1ps
`include "noc_cfg.svh"

module credit_fifo #(
  parameter type payload_t = noc_pkg::flit_t
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output logic     head_valid_o,
  output payload_t head_data_o,
  output logic     credit_o
);

  localparam noc_pkg::fifo_ptr_t LAST_PTR = noc_pkg::fifo_ptr_t'(`NOC_FIFO_DEPTH - 1);
  localparam noc_pkg::fifo_cnt_t FULL_CNT = noc_pkg::fifo_cnt_t'(`NOC_FIFO_DEPTH);

  payload_t           mem_q [`NOC_FIFO_DEPTH];
  noc_pkg::fifo_ptr_t wr_ptr_q;
  noc_pkg::fifo_ptr_t rd_ptr_q;
  noc_pkg::fifo_cnt_t count_q;
  logic               credit_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // one credit back upstream per freed slot
      credit_q <= pop_i;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_data_o  = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

  // upstream must hold a credit for every flit it sends
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> count_q != FULL_CNT);

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> count_q != '0);

endmodule

/* xy_route.sv */
`timescale 1ns/1ps
`include "noc_cfg.svh"

module xy_route (
  input  noc_pkg::coord_t dest_x_i,
  input  noc_pkg::coord_t dest_y_i,
  output noc_pkg::port_e  nexthop_o
);

  localparam noc_pkg::coord_t MY_X = noc_pkg::coord_t'(`NOC_MY_X);
  localparam noc_pkg::coord_t MY_Y = noc_pkg::coord_t'(`NOC_MY_Y);

  // x first, then y
  always_comb begin
    if (dest_x_i < MY_X) begin
      nexthop_o = noc_pkg::PORT_W;
    end else if (dest_x_i > MY_X) begin
      nexthop_o = noc_pkg::PORT_E;
    end else if (dest_y_i < MY_Y) begin
      nexthop_o = noc_pkg::PORT_N;
    end else if (dest_y_i > MY_Y) begin
      nexthop_o = noc_pkg::PORT_S;
    end else begin
      // arrived, eject locally
      nexthop_o = noc_pkg::PORT_L;
    end
  end

endmodule

/* w_rr_processor.sv */
`timescale 1ns/1ps

module w_rr_processor (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  noc_pkg::port_e   nexthop_i [4],
  input  logic [3:0]       head_valid_i,
  input  logic             downstream_credit_i,
  output logic [3:0]       grant_o,
  output noc_pkg::in_idx_e grant_idx_o
);

  // order_q[0] holds the input with highest priority
  noc_pkg::in_idx_e order_q [4];
  logic [3:0]       w_desire;
  logic             found;
  noc_pkg::in_idx_e winner;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      w_desire[i] = head_valid_i[i] && (nexthop_i[i] == noc_pkg::PORT_W);
    end
  end

  // first desiring input in the current order
  always_comb begin
    found  = 1'b0;
    winner = order_q[0];
    for (int k = 0; k < 4; k++) begin
      if (!found && w_desire[order_q[k]]) begin
        found  = 1'b1;
        winner = order_q[k];
      end
    end
  end

  always_comb begin
    grant_o = '0;
    if (found && downstream_credit_i) begin
      grant_o[winner] = 1'b1;
    end
  end

  assign grant_idx_o = winner;

  // change order on every grant, successor of the winner goes first
  // successor in N,S,E,L order is simply index minus one
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      order_q[0] <= noc_pkg::IDX_N;
      order_q[1] <= noc_pkg::IDX_S;
      order_q[2] <= noc_pkg::IDX_E;
      order_q[3] <= noc_pkg::IDX_L;
    end else if (|grant_o) begin
      for (int k = 0; k < 4; k++) begin
        order_q[k] <= noc_pkg::in_idx_e'(2'(winner) - 2'(k + 1));
      end
    end
  end

  // winner drops to the back, so it loses to any other desiring input
  a_winner_not_repeated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |grant_o |=> ((w_desire & ~$past(grant_o)) == '0) ||
                 ((grant_o & $past(grant_o)) == '0));

  // every input stays in the order, so a desire with a credit is served
  a_work_conserving: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|w_desire && downstream_credit_i) |-> |grant_o);

endmodule

/* w_credit_counter.sv */
`timescale 1ns/1ps
`include "noc_cfg.svh"

module w_credit_counter (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic spend_i,
  input  logic credit_i,
  output logic credit_avail_o
);

  localparam noc_pkg::w_credit_cnt_t MAX_CNT = noc_pkg::w_credit_cnt_t'(`NOC_W_CREDITS);

  noc_pkg::w_credit_cnt_t count_q;

  // west neighbour starts with an empty buffer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= MAX_CNT;
    end else begin
      case ({spend_i, credit_i})
        2'b10:   count_q <= count_q - 1'b1;
        2'b01:   count_q <= count_q + 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign credit_avail_o = (count_q != '0);

  a_no_spend_at_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    spend_i |-> count_q != '0);

  // neighbour returns no more than it was sent
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (credit_i && !spend_i) |-> count_q < MAX_CNT);

endmodule

/* w_output_port.sv */
`timescale 1ns/1ps

module w_output_port (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  noc_pkg::flit_link_t head_i [4],
  input  noc_pkg::port_e      nexthop_i [4],
  output logic [3:0]          pop_o,
  output noc_pkg::flit_link_t w_link_o,
  input  logic                w_credit_i
);

  logic [3:0]       head_valid;
  logic [3:0]       grant;
  noc_pkg::in_idx_e grant_idx;
  logic             credit_avail;
  logic             spend;
  logic             valid_q;
  noc_pkg::flit_t   flit_q;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      head_valid[i] = head_i[i].valid;
    end
  end

  w_rr_processor w_rr_proc (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .nexthop_i           (nexthop_i),
    .head_valid_i        (head_valid),
    .downstream_credit_i (credit_avail),
    .grant_o             (grant),
    .grant_idx_o         (grant_idx)
  );

  w_credit_counter w_credit_cnt (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .spend_i        (spend),
    .credit_i       (w_credit_i),
    .credit_avail_o (credit_avail)
  );

  // every flit sent west costs one credit
  assign spend = |grant;
  assign pop_o = grant;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= spend;
    end
  end

  // crossbar leg, granted head onto the output register
  always_ff @(posedge clk_i) begin
    if (spend) begin
      flit_q <= head_i[grant_idx].flit;
    end
  end

  always_comb begin
    w_link_o.valid = valid_q;
    w_link_o.flit  = flit_q;
  end

endmodule

/* router_w_slice_top.sv */
`timescale 1ns/1ps

module router_w_slice_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  noc_pkg::flit_link_t in_link_i [4],
  output logic [3:0]          in_credit_o,
  input  logic [3:0]          other_take_i,
  output logic [3:0]          hol_valid_o,
  output noc_pkg::port_e      hol_port_o [4],
  output noc_pkg::flit_link_t w_link_o,
  input  logic                w_credit_i
);

  noc_pkg::flit_t      head_data [4];
  noc_pkg::flit_link_t head_link [4];
  logic [3:0]          west_pop;
  logic [3:0]          fifo_pop;

  for (genvar i = 0; i < 4; i++) begin : g_in
    // head leaves either westward or through the other outputs
    assign fifo_pop[i] = west_pop[i] | other_take_i[i];

    credit_fifo #(
      .payload_t (noc_pkg::flit_t)
    ) in_fifo (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .push_i       (in_link_i[i].valid),
      .push_data_i  (in_link_i[i].flit),
      .pop_i        (fifo_pop[i]),
      .head_valid_o (hol_valid_o[i]),
      .head_data_o  (head_data[i]),
      .credit_o     (in_credit_o[i])
    );

    xy_route in_route (
      .dest_x_i  (head_data[i].dest_x),
      .dest_y_i  (head_data[i].dest_y),
      .nexthop_o (hol_port_o[i])
    );

    assign head_link[i] = '{valid: hol_valid_o[i], flit: head_data[i]};

    // environment only removes heads that are not bound west
    a_take_not_west: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      other_take_i[i] |-> hol_valid_o[i] && (hol_port_o[i] != noc_pkg::PORT_W));
  end

  w_output_port w_port (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .head_i     (head_link),
    .nexthop_i  (hol_port_o),
    .pop_o      (west_pop),
    .w_link_o   (w_link_o),
    .w_credit_i (w_credit_i)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

/* router_w_tb.sv */
`timescale 1ns/1ps
`include "noc_cfg.svh"

module router_w_tb;

  logic                clk;
  logic                rst_n;
  noc_pkg::flit_link_t in_link [4];
  logic [3:0]          in_credit;
  logic [3:0]          other_take;
  logic [3:0]          hol_valid;
  noc_pkg::port_e      hol_port [4];
  noc_pkg::flit_link_t w_link;
  logic                w_credit;

  // reference model of buffers, credits and the west neighbour
  noc_pkg::flit_t fifo_q [4][$];
  int             ret_q [$];
  int             up_credits [4];
  int             removed [4];
  int             returned [4];
  int             outstanding;
  int             arrivals;
  int             last_arr_cyc;
  int             takes;
  int             cyc;
  int             rr_count;
  bit             rr_on;
  bit             hold_credits;
  int             ret_delay_max;

  tb_clk_gen clk_gen (
    .clk_o (clk)
  );

  router_w_slice_top router_w_slice_top_inst (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .in_link_i    (in_link),
    .in_credit_o  (in_credit),
    .other_take_i (other_take),
    .hol_valid_o  (hol_valid),
    .hol_port_o   (hol_port),
    .w_link_o     (w_link),
    .w_credit_i   (w_credit)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("Fail %s: expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // x first, then y
  function automatic noc_pkg::port_e expected_hop(input noc_pkg::flit_t f);
    if (int'(f.dest_x) < `NOC_MY_X) begin
      return noc_pkg::PORT_W;
    end
    if (int'(f.dest_x) > `NOC_MY_X) begin
      return noc_pkg::PORT_E;
    end
    if (int'(f.dest_y) < `NOC_MY_Y) begin
      return noc_pkg::PORT_N;
    end
    if (int'(f.dest_y) > `NOC_MY_Y) begin
      return noc_pkg::PORT_S;
    end
    return noc_pkg::PORT_L;
  endfunction

  function automatic noc_pkg::port_e port_of_input(input int i);
    case (i)
      3:       return noc_pkg::PORT_N;
      2:       return noc_pkg::PORT_S;
      1:       return noc_pkg::PORT_E;
      default: return noc_pkg::PORT_L;
    endcase
  endfunction

  function automatic int input_of_port(input noc_pkg::port_e p);
    case (p)
      noc_pkg::PORT_N: return 3;
      noc_pkg::PORT_S: return 2;
      noc_pkg::PORT_E: return 1;
      noc_pkg::PORT_L: return 0;
      default:         return -1;
    endcase
  endfunction

  function automatic noc_pkg::flit_t random_flit(input int i, input bit west);
    noc_pkg::flit_t f;
    logic [31:0]    r;
    if (west) begin
      f.dest_x = noc_pkg::coord_t'($urandom_range(`NOC_MY_X - 1, 0));
    end else begin
      f.dest_x = noc_pkg::coord_t'($urandom_range((1 << `NOC_COORD_W) - 1, 0));
    end
    f.dest_y  = noc_pkg::coord_t'($urandom_range((1 << `NOC_COORD_W) - 1, 0));
    f.src     = port_of_input(i);
    r         = $urandom;
    f.payload = r[`NOC_PAYLOAD_W-1:0];
    return f;
  endfunction

  task automatic send_flit(input int i, input noc_pkg::flit_t f);
    up_credits[i]--;
    in_link[i].valid = 1'b1;
    in_link[i].flit  = f;
    fifo_q[i].push_back(f);
  endtask

  task automatic observe_outputs();
    noc_pkg::flit_t f;
    int             idx;
    if (w_link.valid) begin
      f   = w_link.flit;
      idx = input_of_port(f.src);
      check_equal("west flit source", 1, 32'(idx >= 0));
      check_equal("west flit buffered", 1, 32'(fifo_q[idx].size() > 0));
      check_equal("west flit order", 32'(fifo_q[idx][0]), 32'(f));
      check_equal("west flit route", 32'(noc_pkg::PORT_W), 32'(expected_hop(f)));
      void'(fifo_q[idx].pop_front());
      removed[idx]++;
      if (rr_on) begin
        check_equal("round robin source", 32'(port_of_input(3 - rr_count % 4)), 32'(f.src));
        rr_count++;
      end
      outstanding++;
      check_equal("west credit bound", 1, 32'(outstanding <= `NOC_W_CREDITS));
      ret_q.push_back(cyc + int'($urandom_range(ret_delay_max, 0)));
      arrivals++;
      last_arr_cyc = cyc;
    end
    for (int i = 0; i < 4; i++) begin
      if (in_credit[i]) begin
        up_credits[i]++;
        returned[i]++;
      end
      check_equal("upstream credit count", 1,
                  32'(up_credits[i] <= `NOC_FIFO_DEPTH && returned[i] <= removed[i]));
      check_equal("head valid", 32'(fifo_q[i].size() > 0), 32'(hol_valid[i]));
      if (hol_valid[i]) begin
        check_equal("head next hop", 32'(expected_hop(fifo_q[i][0])), 32'(hol_port[i]));
      end
    end
  endtask

  // rest of the router removes other heads, west neighbour frees slots
  task automatic service_inputs();
    other_take = '0;
    w_credit   = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (fifo_q[i].size() > 0 && expected_hop(fifo_q[i][0]) != noc_pkg::PORT_W &&
          $urandom_range(1, 0) == 1) begin
        other_take[i] = 1'b1;
        void'(fifo_q[i].pop_front());
        removed[i]++;
        takes++;
      end
    end
    if (!hold_credits && ret_q.size() > 0 && ret_q[0] <= cyc) begin
      w_credit = 1'b1;
      void'(ret_q.pop_front());
      outstanding--;
    end
  endtask

  task automatic advance_cycle();
    @(negedge clk);
    cyc++;
    for (int i = 0; i < 4; i++) begin
      in_link[i].valid = 1'b0;
    end
    observe_outputs();
    service_inputs();
  endtask

  task automatic wait_arrivals(input int target, input int limit, input string msg);
    int n;
    n = 0;
    while (arrivals < target && n < limit) begin
      advance_cycle();
      n++;
    end
    if (arrivals < target) begin
      fail_run(msg);
    end
  endtask

  function automatic bit all_drained();
    bit done;
    done = (ret_q.size() == 0) && (outstanding == 0);
    for (int i = 0; i < 4; i++) begin
      if (fifo_q[i].size() != 0 || up_credits[i] != `NOC_FIFO_DEPTH) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (!all_drained() && n < limit) begin
      advance_cycle();
      n++;
    end
    if (!all_drained()) begin
      fail_run("timeout while the slice drained its buffers and credits");
    end
  endtask

  initial begin
    int sent_cyc;
    void'($urandom(32'h199e_d377));
    rst_n      = 1'b0;
    other_take = '0;
    w_credit   = 1'b0;
    for (int i = 0; i < 4; i++) begin
      in_link[i]    = '0;
      up_credits[i] = `NOC_FIFO_DEPTH;
      removed[i]    = 0;
      returned[i]   = 0;
    end
    outstanding   = 0;
    arrivals      = 0;
    last_arr_cyc  = 0;
    takes         = 0;
    cyc           = 0;
    rr_count      = 0;
    rr_on         = 1'b1;
    hold_credits  = 1'b1;
    ret_delay_max = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_equal("reset west valid", 0, 32'(w_link.valid));
    check_equal("reset upstream credits", 0, 32'(in_credit));
    check_equal("reset head valid", 0, 32'(hol_valid));

    // preload all inputs with west-bound flits, neighbour silent
    repeat (3) begin
      advance_cycle();
      for (int i = 0; i < 4; i++) begin
        send_flit(i, random_flit(i, 1'b1));
      end
    end
    wait_arrivals(`NOC_W_CREDITS, 40, "timeout waiting for the first west flits");
    repeat (20) advance_cycle();
    check_equal("west flits without credit return", `NOC_W_CREDITS, arrivals);
    hold_credits = 1'b0;
    wait_arrivals(12, 200, "timeout waiting for the round robin flits");
    rr_on = 1'b0;

    // random mixed traffic
    ret_delay_max = 6;
    repeat (400) begin
      advance_cycle();
      for (int i = 0; i < 4; i++) begin
        if (up_credits[i] > 0 && $urandom_range(1, 0) == 1) begin
          send_flit(i, random_flit(i, bit'($urandom_range(1, 0))));
        end
      end
    end
    wait_drained(300);
    for (int i = 0; i < 4; i++) begin
      check_equal("credits returned per input", removed[i], returned[i]);
    end
    check_equal("bypass flits taken", 1, 32'(takes > 0));

    // idle latency of one west flit
    advance_cycle();
    send_flit(0, random_flit(0, 1'b1));
    sent_cyc = cyc;
    wait_arrivals(arrivals + 1, 10, "timeout waiting for the single west flit");
    check_equal("single flit latency", 2, last_arr_cyc - sent_cyc);
    wait_drained(50);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
noc_pkg.sv
credit_fifo.sv
xy_route.sv
w_rr_processor.sv
w_credit_counter.sv
w_output_port.sv
router_w_slice_top.sv
tb_clk_gen.sv
router_w_tb.sv

/* run.sh */
#!/bin/sh
# builds the west slice testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module router_w_tb -f flist.f -o router_w_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/router_w_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
